// ==== Makefile ====
# Verilator flow for the memory controller testbench
TOP := mem_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Everything OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass"; \
		exit 1; \
	fi

obj_dir/V$(TOP): sources.f $(wildcard logic/*.sv tests/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/dp_bram.sv ====
// Behavioral dual-port RAM, one cycle read latency on both ports.
// Port A writes byte lanes write-first; port B also sees a same-cycle port A write.
`timescale 1ns/1ps

module dp_bram
    import mem_pkg::*;
#(
    parameter int depth = 128
) (
    input  logic                     clock,
    input  logic [$clog2(depth)-1:0] a_addr,
    input  logic [data_w-1:0]        a_wdata,
    input  logic [lanes_w-1:0]       a_we,
    output logic [data_w-1:0]        a_rdata,
    input  logic [$clog2(depth)-1:0] b_addr,
    output logic [data_w-1:0]        b_rdata
);

    logic [data_w-1:0] mem [depth];
    logic [data_w-1:0] a_merged;

    // Old word with the enabled lanes replaced
    always_comb begin
        a_merged = mem[a_addr];
        for (int i = 0; i < lanes_w; i++) begin
            if (a_we[i]) begin
                a_merged[i*8 +: 8] = a_wdata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (|a_we) begin
            mem[a_addr] <= a_merged;
        end
        a_rdata <= a_merged;
        b_rdata <= (b_addr == a_addr) ? a_merged : mem[b_addr];
    end

endmodule

// ==== logic/intern_ram.sv ====
// Internal work RAM, 32 KiB. Only byte address bits 14 to 2 are decoded,
// so the region mirrors across its whole block.
`timescale 1ns/1ps

module intern_ram
    import mem_pkg::*;
(
    input logic        clock,
    mem_port_if.region port
);

    localparam int ram_aw = $clog2(intern_depth);

    logic [data_w-1:0] ram_rdata;

    dp_bram #(
        .depth(intern_depth)
    ) u_ram (
        .clock   (clock),
        .a_addr  (port.word_addr[ram_aw-1:0]),
        .a_wdata (port.wdata),
        .a_we    (port.byte_we),
        .a_rdata (ram_rdata),
        .b_addr  ('0),
        .b_rdata ()
    );

    assign port.rdata = ram_rdata;

endmodule

// ==== logic/io_regs.sv ====
// Memory-mapped I/O words. Buttons, vcount and the interrupt flags are read-only
// halves; writing the upper half of the irq word only pulses int_acks.
`timescale 1ns/1ps

module io_regs
    import mem_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    mem_port_if.region  port,
    input  logic [15:0] buttons,
    input  logic [15:0] vcount,
    input  logic [15:0] reg_if,
    output logic [15:0] int_acks
);

    localparam int idx_w = $clog2(io_words);

    logic [data_w-1:0] regs [io_words];
    logic [data_w-1:0] view [io_words];
    logic [idx_w-1:0]  idx;
    logic [idx_w-1:0]  rd_idx_q;
    logic              irq_hit;
    logic              commit_q;

    assign idx     = port.word_addr[idx_w-1:0];
    assign irq_hit = (idx == idx_w'(irq_idx));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int w = 0; w < io_words; w++) begin
                regs[w] <= '0;
            end
            int_acks <= '0;
            rd_idx_q <= '0;
            commit_q <= 1'b0;
        end else begin
            for (int i = 0; i < lanes_w; i++) begin
                if (port.byte_we[i]) begin
                    regs[idx][i*8 +: 8] <= port.wdata[i*8 +: 8];
                end
            end
            // Acks last one cycle unless rewritten
            int_acks[7:0]  <= (irq_hit && port.byte_we[2]) ? port.wdata[23:16] : 8'h00;
            int_acks[15:8] <= (irq_hit && port.byte_we[3]) ? port.wdata[31:24] : 8'h00;
            rd_idx_q <= idx;
            commit_q <= |port.byte_we;
        end
    end

    // Substitute the read-only halves
    always_comb begin
        for (int w = 0; w < io_words; w++) begin
            view[w] = regs[w];
        end
        view[vcount_idx][31:16]  = vcount;
        view[keyinput_idx][15:0] = buttons;
        view[irq_idx][31:16]     = reg_if;
    end

    assign port.rdata = view[rd_idx_q];

    assert property (@(posedge clock) disable iff (reset) !commit_q |-> int_acks == '0);

endmodule

// ==== logic/mem_bus_front.sv ====
// CPU bus front end. Writes are latched and committed one cycle later under a
// single pause pulse; the CPU must hold its inputs while bus_pause is high.
// Unmapped reads return zero.
`timescale 1ns/1ps

module mem_bus_front
    import mem_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic [addr_w-1:0] bus_addr,
    input  logic [data_w-1:0] bus_wdata,
    input  logic [1:0]        bus_size,
    input  logic              bus_write,
    output logic [data_w-1:0] bus_rdata,
    output logic              bus_pause,
    mem_port_if.front         intern_port,
    mem_port_if.front         palette_port,
    mem_port_if.front         io_port
);

    logic [addr_w-1:0]  bus_addr_lat;
    logic [1:0]         bus_size_lat;
    logic [addr_w-1:0]  mem_addr;
    logic [addr_w-1:0]  intern_off;
    logic [addr_w-1:0]  palette_off;
    logic [addr_w-1:0]  io_off;
    logic [lanes_w-1:0] byte_we;
    region_t            region;

    // Pause doubles as the accepted-write flag for the commit cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bus_addr_lat <= '0;
            bus_size_lat <= '0;
            bus_pause    <= 1'b0;
        end else begin
            bus_addr_lat <= bus_addr;
            bus_size_lat <= bus_size;
            bus_pause    <= bus_write & ~bus_pause;
        end
    end

    assign mem_addr = bus_pause ? bus_addr_lat : bus_addr;

    // Byte lanes, little endian
    always_comb begin
        byte_we = '0;
        if (bus_pause) begin
            case (mem_size_t'(bus_size_lat))
                size_byte: byte_we[bus_addr_lat[1:0]] = 1'b1;
                size_half: byte_we = bus_addr_lat[1] ? 4'b1100 : 4'b0011;
                size_word: byte_we = 4'b1111;
                default:   byte_we = '0;
            endcase
        end
    end

    // Region of the latched address serves both the commit and the read select
    always_comb begin
        if (bus_addr_lat[31:24] == intern_base[31:24]) begin
            region = rgn_intern;
        end else if (bus_addr_lat[31:24] == palette_base[31:24]) begin
            region = rgn_palette;
        end else if ((bus_addr_lat - io_base) < addr_w'(io_words * lanes_w)) begin
            region = rgn_io;
        end else begin
            region = rgn_none;
        end
    end

    assign intern_off  = mem_addr - intern_base;
    assign palette_off = mem_addr - palette_base;
    assign io_off      = mem_addr - io_base;

    assign intern_port.word_addr  = intern_off[addr_w-1:2];
    assign palette_port.word_addr = palette_off[addr_w-1:2];
    assign io_port.word_addr      = io_off[addr_w-1:2];

    assign intern_port.wdata  = bus_wdata;
    assign palette_port.wdata = bus_wdata;
    assign io_port.wdata      = bus_wdata;

    assign intern_port.byte_we  = (region == rgn_intern) ? byte_we : '0;
    assign palette_port.byte_we = (region == rgn_palette) ? byte_we : '0;
    assign io_port.byte_we      = (region == rgn_io) ? byte_we : '0;

    always_comb begin
        case (region)
            rgn_intern:  bus_rdata = intern_port.rdata;
            rgn_palette: bus_rdata = palette_port.rdata;
            rgn_io:      bus_rdata = io_port.rdata;
            default:     bus_rdata = '0;
        endcase
    end

    // A held write is only re-accepted after a free cycle
    assert property (@(posedge clock) disable iff (reset) bus_pause |=> !bus_pause);

    assert property (@(posedge clock) disable iff (reset)
        $onehot0({|intern_port.byte_we, |palette_port.byte_we, |io_port.byte_we}));

endmodule

// ==== logic/mem_pkg.sv ====
// Shared widths, address map and encodings for the memory controller.
// Region bases assume the handheld map: work RAM 0x03, I/O 0x04, palette 0x05.
package mem_pkg;

    localparam int addr_w  = 32;
    localparam int data_w  = 32;
    localparam int lanes_w = 4;

    // Work RAM, mirrored across the whole 0x03 block
    localparam logic [addr_w-1:0] intern_base = 32'h0300_0000;
    localparam int intern_depth = 8192;

    // Palette banks, background below the object offset
    localparam logic [addr_w-1:0] palette_base = 32'h0500_0000;
    localparam int palette_depth = 128;
    localparam int palette_obj_offset = 'h200;

    // Memory-mapped I/O words
    localparam logic [addr_w-1:0] io_base = 32'h0400_0000;
    localparam int io_words = 8;
    localparam int vcount_idx = 1;
    localparam int keyinput_idx = 4;
    localparam int irq_idx = 6;

    typedef enum logic [1:0] {
        rgn_intern,
        rgn_palette,
        rgn_io,
        rgn_none
    } region_t;

    // Codes as driven on bus_size
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

endpackage

// ==== logic/mem_port_if.sv ====
// One region's slice of the CPU bus.
// byte_we arrives already gated, so it is zero unless this region is addressed.
`timescale 1ns/1ps

interface mem_port_if
    import mem_pkg::*;
();

    // Word index relative to the region base
    logic [addr_w-3:0]  word_addr;
    logic [data_w-1:0]  wdata;
    logic [lanes_w-1:0] byte_we;
    logic [data_w-1:0]  rdata;

    modport front (output word_addr, wdata, byte_we, input rdata);

    modport region (input word_addr, wdata, byte_we, output rdata);

endinterface

// ==== logic/mem_top.sv ====
// Memory controller top: work RAM, palette RAM and I/O words on one CPU bus.
// No handshake; the CPU holds its bus inputs while bus_pause is high.
`timescale 1ns/1ps

module mem_top (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] bus_addr,
    input  logic [31:0] bus_wdata,
    input  logic [1:0]  bus_size,
    input  logic        bus_write,
    output logic [31:0] bus_rdata,
    output logic        bus_pause,
    input  logic [31:0] gfx_palette_bg_addr,
    input  logic [31:0] gfx_palette_obj_addr,
    output logic [31:0] gfx_palette_bg_data,
    output logic [31:0] gfx_palette_obj_data,
    input  logic [15:0] buttons,
    input  logic [15:0] vcount,
    input  logic [15:0] reg_if,
    output logic [15:0] int_acks
);

    mem_port_if intern_port ();
    mem_port_if palette_port ();
    mem_port_if io_port ();

    mem_bus_front u_front (
        .clock        (clock),
        .reset        (reset),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_size     (bus_size),
        .bus_write    (bus_write),
        .bus_rdata    (bus_rdata),
        .bus_pause    (bus_pause),
        .intern_port  (intern_port),
        .palette_port (palette_port),
        .io_port      (io_port)
    );

    intern_ram u_intern (
        .clock (clock),
        .port  (intern_port)
    );

    palette_ram u_palette (
        .clock        (clock),
        .port         (palette_port),
        .gfx_bg_addr  (gfx_palette_bg_addr),
        .gfx_obj_addr (gfx_palette_obj_addr),
        .gfx_bg_data  (gfx_palette_bg_data),
        .gfx_obj_data (gfx_palette_obj_data)
    );

    io_regs u_io (
        .clock    (clock),
        .reset    (reset),
        .port     (io_port),
        .buttons  (buttons),
        .vcount   (vcount),
        .reg_if   (reg_if),
        .int_acks (int_acks)
    );

endmodule

// ==== logic/palette_ram.sv ====
// Palette RAM with background and object banks.
// Graphics ports take a byte address and use bits 8 to 2 within their bank.
`timescale 1ns/1ps

module palette_ram
    import mem_pkg::*;
(
    input  logic              clock,
    mem_port_if.region        port,
    input  logic [addr_w-1:0] gfx_bg_addr,
    input  logic [addr_w-1:0] gfx_obj_addr,
    output logic [data_w-1:0] gfx_bg_data,
    output logic [data_w-1:0] gfx_obj_data
);

    localparam int bank_aw = $clog2(palette_depth);
    // Word address bit that selects the object bank
    localparam int obj_bit = $clog2(palette_obj_offset) - 2;

    logic               obj_sel;
    logic               obj_sel_q;
    logic [lanes_w-1:0] bg_we;
    logic [lanes_w-1:0] obj_we;
    logic [data_w-1:0]  bg_rdata;
    logic [data_w-1:0]  obj_rdata;

    assign obj_sel = port.word_addr[obj_bit];
    assign bg_we   = obj_sel ? '0 : port.byte_we;
    assign obj_we  = obj_sel ? port.byte_we : '0;

    // Bank of the address that the RAMs are reading this cycle
    always_ff @(posedge clock) begin
        obj_sel_q <= obj_sel;
    end

    assign port.rdata = obj_sel_q ? obj_rdata : bg_rdata;

    dp_bram #(
        .depth(palette_depth)
    ) u_bg (
        .clock   (clock),
        .a_addr  (port.word_addr[bank_aw-1:0]),
        .a_wdata (port.wdata),
        .a_we    (bg_we),
        .a_rdata (bg_rdata),
        .b_addr  (gfx_bg_addr[bank_aw+1:2]),
        .b_rdata (gfx_bg_data)
    );

    dp_bram #(
        .depth(palette_depth)
    ) u_obj (
        .clock   (clock),
        .a_addr  (port.word_addr[bank_aw-1:0]),
        .a_wdata (port.wdata),
        .a_we    (obj_we),
        .a_rdata (obj_rdata),
        .b_addr  (gfx_obj_addr[bank_aw+1:2]),
        .b_rdata (gfx_obj_data)
    );

endmodule

// ==== sources.f ====
logic/mem_pkg.sv
logic/mem_port_if.sv
logic/dp_bram.sv
logic/mem_bus_front.sv
logic/intern_ram.sv
logic/palette_ram.sv
logic/io_regs.sv
logic/mem_top.sv
tests/mem_tb.sv

// ==== tests/mem_tb.sv ====
// Testbench for mem_top. A shadow model predicts bus, graphics and acknowledge
// results; concurrent assertions compare them in the response cycle.
// RAM words are only read after a full-word write, since reset leaves them undefined.
`timescale 1ns/1ps

module mem_tb
    import mem_pkg::*;
();

    localparam int seed          = 66932;
    localparam int pause_timeout = 8;

    logic        clock;
    logic        reset;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [1:0]  bus_size;
    logic        bus_write;
    logic [31:0] bus_rdata;
    logic        bus_pause;
    logic [31:0] gfx_palette_bg_addr;
    logic [31:0] gfx_palette_obj_addr;
    logic [31:0] gfx_palette_bg_data;
    logic [31:0] gfx_palette_obj_data;
    logic [15:0] buttons;
    logic [15:0] vcount;
    logic [15:0] reg_if;
    logic [15:0] int_acks;

    // Shadow copies of every storage region
    logic [31:0] intern_mem [intern_depth];
    logic [31:0] pal_bg [palette_depth];
    logic [31:0] pal_obj [palette_depth];
    logic [31:0] io_mem [io_words];

    // Expected values are driven with the request and delayed to the response
    logic        rd_issue;
    logic [31:0] rd_expect;
    logic        rd_check;
    logic [31:0] rd_want;
    logic        gfx_issue;
    logic [31:0] gfx_expect_bg;
    logic [31:0] gfx_expect_obj;
    logic        gfx_check;
    logic [31:0] gfx_want_bg;
    logic [31:0] gfx_want_obj;
    logic [15:0] ack_expect;
    logic [15:0] ack_s1;
    logic [15:0] ack_want;

    string test_name;
    int    errors;
    int    errors_at_start;
    int    tests_run;

    mem_top dut (.*);

    always #10 clock = ~clock;

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_check    <= 1'b0;
            rd_want     <= '0;
            gfx_check   <= 1'b0;
            gfx_want_bg <= '0;
            gfx_want_obj <= '0;
            ack_s1      <= '0;
            ack_want    <= '0;
        end else begin
            rd_check    <= rd_issue;
            rd_want     <= rd_expect;
            gfx_check   <= gfx_issue;
            gfx_want_bg <= gfx_expect_bg;
            gfx_want_obj <= gfx_expect_obj;
            // Ack shows in the cycle after the commit, two edges after the request
            ack_s1      <= ack_expect;
            ack_want    <= ack_s1;
        end
    end

    assert property (@(posedge clock) disable iff (reset) rd_check |-> bus_rdata == rd_want)
        else flag_mismatch("bus_rdata", $sampled(rd_want), $sampled(bus_rdata));

    assert property (@(posedge clock) disable iff (reset)
        gfx_check |-> gfx_palette_bg_data == gfx_want_bg)
        else flag_mismatch("gfx_bg_data", $sampled(gfx_want_bg), $sampled(gfx_palette_bg_data));

    assert property (@(posedge clock) disable iff (reset)
        gfx_check |-> gfx_palette_obj_data == gfx_want_obj)
        else flag_mismatch("gfx_obj_data", $sampled(gfx_want_obj),
            $sampled(gfx_palette_obj_data));

    assert property (@(posedge clock) disable iff (reset) int_acks == ack_want)
        else flag_mismatch("int_acks", {16'h0, $sampled(ack_want)}, {16'h0, $sampled(int_acks)});

    assert property (@(posedge clock) disable iff (reset) (bus_write && !bus_pause) |=> bus_pause)
        else flag_event("a write request was not followed by a pause cycle");

    assert property (@(posedge clock) disable iff (reset)
        !(bus_write && !bus_pause) |=> !bus_pause)
        else flag_event("bus_pause was high without a fresh write request");

    task automatic flag_mismatch(input string what, input logic [31:0] want,
                                 input logic [31:0] got);
        $display("Error in %s: %s expected %h, got %h", test_name, what, want, got);
        errors++;
    endtask

    task automatic flag_event(input string what);
        $display("Problem in %s: %s", test_name, what);
        errors++;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test;
        tests_run++;
        $display("Test %s finished with %0d errors", test_name, errors - errors_at_start);
    endtask

    task automatic step;
        @(posedge clock);
        #1;
    endtask

    function automatic region_t region_of(input logic [31:0] a);
        if (a[31:24] == intern_base[31:24]) return rgn_intern;
        if (a[31:24] == palette_base[31:24]) return rgn_palette;
        if ((a - io_base) < 32'h20) return rgn_io;
        return rgn_none;
    endfunction

    function automatic logic [3:0] lane_mask(input mem_size_t size, input logic [31:0] a);
        case (size)
            size_byte: return 4'b0001 << a[1:0];
            size_half: return a[1] ? 4'b1100 : 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] lanes);
        logic [31:0] mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    // I/O word as the CPU sees it, read-only halves taken from the live inputs
    function automatic logic [31:0] io_view(input logic [2:0] w);
        logic [31:0] v;
        v = io_mem[w];
        if (w == 3'(vcount_idx)) v[31:16] = vcount;
        if (w == 3'(keyinput_idx)) v[15:0] = buttons;
        if (w == 3'(irq_idx)) v[31:16] = reg_if;
        return v;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        case (region_of(a))
            rgn_intern:  return intern_mem[a[14:2]];
            rgn_palette: return a[9] ? pal_obj[a[8:2]] : pal_bg[a[8:2]];
            rgn_io:      return io_view(a[4:2]);
            default:     return 32'h0;
        endcase
    endfunction

    function automatic void apply_write(input logic [31:0] a, input logic [31:0] d,
                                        input logic [3:0] lanes);
        case (region_of(a))
            rgn_intern: intern_mem[a[14:2]] = merge_lanes(intern_mem[a[14:2]], d, lanes);
            rgn_palette: begin
                if (a[9]) pal_obj[a[8:2]] = merge_lanes(pal_obj[a[8:2]], d, lanes);
                else pal_bg[a[8:2]] = merge_lanes(pal_bg[a[8:2]], d, lanes);
            end
            rgn_io: io_mem[a[4:2]] = merge_lanes(io_mem[a[4:2]], d, lanes);
            default: ;
        endcase
    endfunction

    // Request in t, hold through the pause in t+1, release in t+2
    task automatic bus_store(input logic [31:0] addr, input logic [31:0] data,
                             input mem_size_t size);
        logic [3:0] lanes;
        int         waited;
        lanes      = lane_mask(size, addr);
        waited     = 0;
        bus_addr   = addr;
        bus_wdata  = data;
        bus_size   = size;
        bus_write  = 1'b1;
        ack_expect = 16'h0;
        if (region_of(addr) == rgn_io && addr[4:2] == 3'(irq_idx)) begin
            ack_expect = {lanes[3] ? data[31:24] : 8'h00, lanes[2] ? data[23:16] : 8'h00};
        end
        step();
        ack_expect = 16'h0;
        while (!bus_pause && waited < pause_timeout) begin
            step();
            waited++;
        end
        if (!bus_pause) begin
            flag_event($sformatf("write to %h saw no pause within %0d cycles", addr,
                pause_timeout));
        end
        step();
        bus_write = 1'b0;
        apply_write(addr, data, lanes);
    endtask

    task automatic bus_load(input logic [31:0] addr);
        bus_addr  = addr;
        bus_write = 1'b0;
        rd_issue  = 1'b1;
        rd_expect = model_read(addr);
        step();
        rd_issue  = 1'b0;
    endtask

    task automatic gfx_load(input logic [31:0] bg_addr, input logic [31:0] obj_addr);
        gfx_palette_bg_addr  = bg_addr;
        gfx_palette_obj_addr = obj_addr;
        gfx_issue      = 1'b1;
        gfx_expect_bg  = pal_bg[bg_addr[8:2]];
        gfx_expect_obj = pal_obj[obj_addr[8:2]];
        step();
        gfx_issue      = 1'b0;
    endtask

    task automatic after_reset;
        start_test("after_reset");
        assert (bus_pause == 1'b0) else flag_mismatch("bus_pause", 32'h0, {31'h0, bus_pause});
        assert (int_acks == 16'h0) else flag_mismatch("int_acks", 32'h0, {16'h0, int_acks});
        for (int w = 0; w < io_words; w++) begin
            bus_load(io_base + 32'(4 * w));
        end
        bus_store(io_base, 32'h1234_5678, size_word);
        bus_load(io_base);
        finish_test();
    endtask

    task automatic work_ram_traffic;
        logic [31:0] pool [16];
        logic [31:0] addr;
        start_test("work_ram");
        for (int i = 0; i < 16; i++) begin
            pool[i] = intern_base | ($urandom & 32'h00FF_FFFC);
            bus_store(pool[i], $urandom, size_word);
        end
        for (int i = 0; i < 32; i++) begin
            addr = pool[4'($urandom)] | ($urandom & 32'h3);
            bus_store(addr, $urandom, mem_size_t'(2'($urandom % 3)));
        end
        // Back to back, through random mirror bits of the 0x03 block
        for (int i = 0; i < 16; i++) begin
            bus_load(pool[i] ^ ($urandom & 32'h00FF_8000));
        end
        finish_test();
    endtask

    task automatic palette_traffic;
        logic [6:0]  idx [8];
        logic [31:0] bg_addr;
        logic [31:0] obj_addr;
        start_test("palette");
        // Words 126 and 127 end the background bank, 0 and 1 start the object bank
        idx[0] = 7'd127;
        idx[1] = 7'd126;
        idx[2] = 7'd0;
        idx[3] = 7'd1;
        for (int i = 4; i < 8; i++) begin
            idx[i] = 7'($urandom);
        end
        for (int i = 0; i < 8; i++) begin
            bg_addr = palette_base + {23'h0, idx[i], 2'b00};
            bus_store(bg_addr, $urandom, size_word);
            bus_store(bg_addr + 32'(palette_obj_offset), $urandom, size_word);
        end
        for (int i = 0; i < 16; i++) begin
            bg_addr = palette_base + {22'h0, 1'($urandom), idx[3'($urandom)], 2'($urandom)};
            bus_store(bg_addr, $urandom, mem_size_t'(2'($urandom % 3)));
        end
        for (int i = 0; i < 8; i++) begin
            bg_addr  = palette_base + {23'h0, idx[i], 2'b00};
            obj_addr = bg_addr + 32'(palette_obj_offset);
            bus_load(bg_addr);
            bus_load(obj_addr);
            // Same words through random mirror bits of the 0x05 block
            bus_load(bg_addr | ($urandom & 32'h00FF_FC00));
            bus_load(obj_addr | ($urandom & 32'h00FF_FC00));
            gfx_load(bg_addr, obj_addr);
        end
        finish_test();
    endtask

    task automatic io_words_readback;
        logic [31:0] addr;
        start_test("io_words");
        for (int w = 0; w < io_words; w++) begin
            bus_store(io_base + 32'(4 * w), $urandom, size_word);
        end
        for (int i = 0; i < 16; i++) begin
            addr = io_base + ($urandom & 32'h1F);
            bus_store(addr, $urandom, mem_size_t'(2'($urandom % 3)));
        end
        // Inputs stay put until the last read of each round has returned
        for (int r = 0; r < 4; r++) begin
            buttons = 16'($urandom);
            vcount  = 16'($urandom);
            reg_if  = 16'($urandom);
            for (int w = 0; w < io_words; w++) begin
                bus_load(io_base + 32'(4 * w));
            end
            step();
        end
        finish_test();
    endtask

    task automatic irq_acknowledge;
        logic [31:0] irq_addr;
        irq_addr = io_base + 32'(4 * irq_idx);
        start_test("irq_ack");
        bus_store(irq_addr, 32'h0000_A5C3, size_half);
        for (int i = 0; i < 4; i++) begin
            bus_store(irq_addr + 32'h2, $urandom, size_half);
        end
        bus_store(irq_addr + 32'h2, $urandom, size_byte);
        bus_store(irq_addr + 32'h3, $urandom, size_byte);
        repeat (3) step();
        bus_load(irq_addr);
        bus_store(irq_addr, $urandom, size_word);
        step();
        bus_load(irq_addr);
        finish_test();
    endtask

    task automatic unmapped_reads;
        logic [31:0] holes [6];
        start_test("unmapped");
        holes = '{32'h0000_0000, 32'h0200_1234, 32'h0400_0020, 32'h0700_0000,
                  32'h0600_0000, 32'hFFFF_FFFC};
        for (int i = 0; i < 6; i++) begin
            bus_load(holes[i]);
            bus_load(io_base);
        end
        // Bit 27 set keeps the top byte away from 0x03, 0x04 and 0x05
        for (int i = 0; i < 8; i++) begin
            bus_load(32'h0800_0000 | $urandom);
        end
        finish_test();
    endtask

    initial begin
        void'($urandom(seed));
        clock     = 1'b0;
        reset     = 1'b1;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_size  = '0;
        bus_write = 1'b0;
        gfx_palette_bg_addr  = '0;
        gfx_palette_obj_addr = '0;
        buttons   = '0;
        vcount    = '0;
        reg_if    = '0;
        rd_issue  = 1'b0;
        rd_expect = '0;
        gfx_issue = 1'b0;
        gfx_expect_bg  = '0;
        gfx_expect_obj = '0;
        ack_expect = '0;
        io_mem    = '{default: 32'h0};
        errors    = 0;
        tests_run = 0;
        test_name = "reset";
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        after_reset();
        work_ram_traffic();
        palette_traffic();
        io_words_readback();
        irq_acknowledge();
        unmapped_reads();
        repeat (2) step();
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
